//--- rtl/gcn_settings.svh
`ifndef GCN_SETTINGS_SVH
`define GCN_SETTINGS_SVH

// graph size
`define GCN_NODES 6
`define GCN_EDGES 6

// feature stream, two features per read
`define GCN_FEATS 96
`define GCN_PAIRS (`GCN_FEATS / 2)

// output classes per node
`define GCN_CLASSES 3

// data widths
`define GCN_FEAT_W 5
`define GCN_WGT_W 5
// worst case 96 * 186 * 31 fits in 21 bits
`define GCN_SCORE_W 21

`endif

//--- rtl/gcn_types_pkg.sv
`include "gcn_settings.svh"

package gcn_types_pkg;

    // node id, 1..6, 0 means no edge
    typedef logic [2:0] node_id_t;

    // unsigned data words
    typedef logic [`GCN_FEAT_W-1:0] feat_t;
    typedef logic [`GCN_WGT_W-1:0] wgt_t;
    // sum of up to 6 neighbour features
    typedef logic [`GCN_FEAT_W+2:0] agg_t;
    typedef logic [`GCN_SCORE_W-1:0] score_t;
    typedef logic [1:0] class_t;

    // shared feature/weight read address
    typedef logic [5:0] pair_addr_t;
    // one row of the adjacency matrix, bit m set for neighbour m
    typedef logic [`GCN_NODES-1:0] adj_row_t;

    // one coordinate-list entry
    typedef struct packed {
        node_id_t a;
        node_id_t b;
    } edge_t;

    typedef edge_t [`GCN_EDGES-1:0] coo_t;

    // [feature of the pair][node]
    typedef feat_t [1:0][`GCN_NODES-1:0] feat_pair_t;
    // [feature of the pair][class]
    typedef wgt_t [1:0][`GCN_CLASSES-1:0] wgt_pair_t;
    // [feature of the pair][node]
    typedef agg_t [1:0][`GCN_NODES-1:0] agg_pair_t;

    // weight pair lined up with the aggregator output
    typedef struct packed {
        logic valid;
        logic last;
        wgt_pair_t wgt;
    } wgt_stage_t;

    typedef class_t [`GCN_NODES-1:0] class_vec_t;

endpackage

//--- rtl/gcn_ctrl_pkg.sv
package gcn_ctrl_pkg;

    // run sequence of the engine
    typedef enum logic [2:0] {
        ST_IDLE,
        // one edge per cycle into the adjacency matrix
        ST_BUILD,
        // 48 pair reads
        ST_FETCH,
        // wait for the argmax to finish
        ST_SCORE,
        // done held, y valid
        ST_FINISHED
    } ctrl_state_t;

    // strobes from the controller to the datapath
    typedef struct packed {
        // one cycle at run start
        logic clear;
        // high through the build phase
        logic build_en;
        // edge being added during build
        logic [2:0] edge_idx;
        // read data present on feat_data and wgt_data
        logic fetch_valid;
    } ctrl_t;

endpackage

//--- rtl/gcn_ctrl.sv
`timescale 1ns/10ps
`include "gcn_settings.svh"

module gcn_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      scores_ready,
    output gcn_ctrl_pkg::ctrl_t       ctrl,
    output logic                      feat_re,
    output gcn_types_pkg::pair_addr_t pair_addr,
    output logic                      done
);
    import gcn_ctrl_pkg::*;
    import gcn_types_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic [2:0]  edge_cnt;
    logic        fetch_valid_r;
    logic        run_start;
    logic        edge_last;
    logic        pair_last;

    // start only counts when no run is in flight
    assign run_start = start && ((state == ST_IDLE) || (state == ST_FINISHED));
    assign edge_last = (edge_cnt == 3'(`GCN_EDGES - 1));
    assign pair_last = (pair_addr == pair_addr_t'(`GCN_PAIRS - 1));

    //////////////////////////////
    // state machine
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE, ST_FINISHED: begin
                if (run_start) state_nxt = ST_BUILD;
            end
            ST_BUILD: begin
                if (edge_last) state_nxt = ST_FETCH;
            end
            ST_FETCH: begin
                if (pair_last) state_nxt = ST_SCORE;
            end
            ST_SCORE: begin
                if (scores_ready) state_nxt = ST_FINISHED;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    //////////////////////////////
    // counters and delayed read strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            edge_cnt      <= '0;
            pair_addr     <= '0;
            fetch_valid_r <= 1'b0;
        end else begin
            state         <= state_nxt;
            // memories answer one cycle after the address
            fetch_valid_r <= feat_re;
            if (run_start) begin
                edge_cnt  <= '0;
                pair_addr <= '0;
            end else begin
                if (state == ST_BUILD) edge_cnt <= edge_cnt + 3'd1;
                if (feat_re) pair_addr <= pair_addr + pair_addr_t'(1);
            end
        end
    end

    assign feat_re = (state == ST_FETCH);
    assign done    = (state == ST_FINISHED);

    // clear is combinational so coo is taken in the start cycle
    assign ctrl = '{
        clear:       run_start,
        build_en:    (state == ST_BUILD),
        edge_idx:    edge_cnt,
        fetch_valid: fetch_valid_r
    };

    // read address stays inside the 48 pairs
    a_pair_range: assert property (@(posedge clk) disable iff (!rst_n)
        feat_re |-> (pair_addr <= pair_addr_t'(`GCN_PAIRS - 1)))
        else $error("pair_addr past last pair during fetch");

endmodule

//--- rtl/neighbor_aggregator.sv
`timescale 1ns/10ps
`include "gcn_settings.svh"

module neighbor_aggregator (
    input  logic                      clk,
    input  logic                      rst_n,
    input  gcn_ctrl_pkg::ctrl_t       ctrl,
    input  gcn_types_pkg::coo_t       coo,
    input  gcn_types_pkg::feat_pair_t feat_data,
    output gcn_types_pkg::agg_pair_t  agg
);
    import gcn_types_pkg::*;

    coo_t                      coo_r;
    adj_row_t [`GCN_NODES-1:0] adj;
    edge_t                     edge_sel;
    logic [2:0]                idx_a;
    logic [2:0]                idx_b;
    logic                      edge_ok;
    agg_pair_t                 agg_nxt;

    // adjacency must stay symmetric with an empty diagonal
    function automatic logic adj_well_formed(input adj_row_t [`GCN_NODES-1:0] rows);
        logic ok;
        ok = 1'b1;
        for (int n = 0; n < `GCN_NODES; n++) begin
            if (rows[n][n]) ok = 1'b0;
            for (int m = 0; m < `GCN_NODES; m++) begin
                if (rows[n][m] != rows[m][n]) ok = 1'b0;
            end
        end
        return ok;
    endfunction

    //////////////////////////////
    // adjacency build
    always_ff @(posedge clk) begin
        if (ctrl.clear) coo_r <= coo;
    end

    assign edge_sel = coo_r[ctrl.edge_idx];
    // ids are 1-based
    assign idx_a    = edge_sel.a - 3'd1;
    assign idx_b    = edge_sel.b - 3'd1;
    // no-edge, self loop and out of range ids are skipped
    assign edge_ok  = (edge_sel.a != '0) && (edge_sel.b != '0) &&
                      (edge_sel.a != edge_sel.b) &&
                      (edge_sel.a <= node_id_t'(`GCN_NODES)) &&
                      (edge_sel.b <= node_id_t'(`GCN_NODES));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adj <= '0;
        end else if (ctrl.clear) begin
            adj <= '0;
        end else if (ctrl.build_en && edge_ok) begin
            // both directions in the same cycle
            adj[idx_a][idx_b] <= 1'b1;
            adj[idx_b][idx_a] <= 1'b1;
        end
    end

    //////////////////////////////
    // neighbour sums
    always_comb begin
        for (int f = 0; f < 2; f++) begin
            for (int n = 0; n < `GCN_NODES; n++) begin
                agg_nxt[f][n] = '0;
                for (int m = 0; m < `GCN_NODES; m++) begin
                    if (adj[n][m]) agg_nxt[f][n] = agg_nxt[f][n] + agg_t'(feat_data[f][m]);
                end
            end
        end
    end

    // one register stage, lines up with weight_aligner
    always_ff @(posedge clk) begin
        if (ctrl.fetch_valid) agg <= agg_nxt;
    end

    a_adj_sym: assert property (@(posedge clk) disable iff (!rst_n)
        adj_well_formed(adj))
        else $error("adjacency matrix not symmetric or has a self loop");

endmodule

//--- rtl/weight_aligner.sv
`timescale 1ns/10ps
`include "gcn_settings.svh"

module weight_aligner (
    input  logic                      clk,
    input  logic                      rst_n,
    input  gcn_ctrl_pkg::ctrl_t       ctrl,
    input  gcn_types_pkg::wgt_pair_t  wgt_data,
    output gcn_types_pkg::wgt_stage_t wgt_stage
);
    import gcn_types_pkg::*;

    pair_addr_t pair_cnt;
    logic       stage_valid;
    logic       stage_last;
    wgt_pair_t  stage_wgt;

    // valid and last tags, same stage depth as the aggregator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_cnt    <= '0;
            stage_valid <= 1'b0;
            stage_last  <= 1'b0;
        end else if (ctrl.clear) begin
            pair_cnt    <= '0;
            stage_valid <= 1'b0;
            stage_last  <= 1'b0;
        end else begin
            stage_valid <= ctrl.fetch_valid;
            // 48th pair by local count
            stage_last  <= ctrl.fetch_valid && (pair_cnt == pair_addr_t'(`GCN_PAIRS - 1));
            if (ctrl.fetch_valid) pair_cnt <= pair_cnt + pair_addr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.fetch_valid) stage_wgt <= wgt_data;
    end

    assign wgt_stage = '{valid: stage_valid, last: stage_last, wgt: stage_wgt};

    // last is the final valid pair, the stream stops right after it
    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        wgt_stage.last |-> wgt_stage.valid ##1 !wgt_stage.valid)
        else $error("last without valid or stream runs past last");

endmodule

//--- rtl/class_scorer.sv
`timescale 1ns/10ps
`include "gcn_settings.svh"

module class_scorer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  gcn_ctrl_pkg::ctrl_t       ctrl,
    input  gcn_types_pkg::agg_pair_t  agg,
    input  gcn_types_pkg::wgt_stage_t wgt_stage,
    output gcn_types_pkg::class_vec_t y,
    output logic                      scores_ready
);
    import gcn_types_pkg::*;

    // [node][class]
    score_t [`GCN_NODES-1:0][`GCN_CLASSES-1:0] acc;
    score_t [`GCN_NODES-1:0][`GCN_CLASSES-1:0] acc_nxt;
    score_t [`GCN_NODES-1:0]                   best_score;
    score_t [`GCN_NODES-1:0]                   best_score_nxt;
    class_vec_t                                best_cls;
    class_vec_t                                best_cls_nxt;
    logic                                      arg_busy;
    class_t                                    arg_cls;
    logic                                      arg_last;

    //////////////////////////////
    // multiply-accumulate
    always_comb begin
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int c = 0; c < `GCN_CLASSES; c++) begin
                // both features of the pair in one step
                acc_nxt[n][c] = acc[n][c] +
                    score_t'(agg[0][n]) * score_t'(wgt_stage.wgt[0][c]) +
                    score_t'(agg[1][n]) * score_t'(wgt_stage.wgt[1][c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.clear) begin
            acc <= '0;
        end else if (wgt_stage.valid) begin
            acc <= acc_nxt;
        end
    end

    //////////////////////////////
    // argmax, one class per cycle
    assign arg_last = (arg_cls == class_t'(`GCN_CLASSES - 1));

    always_comb begin
        for (int n = 0; n < `GCN_NODES; n++) begin
            // class 0 seeds the search, later classes must be strictly larger
            if ((arg_cls == '0) || (acc[n][arg_cls] > best_score[n])) begin
                best_score_nxt[n] = acc[n][arg_cls];
                best_cls_nxt[n]   = arg_cls;
            end else begin
                best_score_nxt[n] = best_score[n];
                best_cls_nxt[n]   = best_cls[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arg_busy) begin
            best_score <= best_score_nxt;
            best_cls   <= best_cls_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arg_busy     <= 1'b0;
            arg_cls      <= '0;
            scores_ready <= 1'b0;
        end else if (ctrl.clear) begin
            arg_busy     <= 1'b0;
            arg_cls      <= '0;
            scores_ready <= 1'b0;
        end else begin
            // pulse one cycle after the class 2 step
            scores_ready <= arg_busy && arg_last;
            if (wgt_stage.valid && wgt_stage.last) begin
                // last pair accumulates on this edge, search starts next cycle
                arg_busy <= 1'b1;
                arg_cls  <= '0;
            end else if (arg_busy) begin
                if (arg_last) begin
                    arg_busy <= 1'b0;
                    arg_cls  <= '0;
                end else begin
                    arg_cls <= arg_cls + class_t'(1);
                end
            end
        end
    end

    // y only moves at the end of a search, so it holds between runs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y <= '0;
        end else if (arg_busy && arg_last) begin
            y <= best_cls_nxt;
        end
    end

endmodule

//--- rtl/gcn_top.sv
`timescale 1ns/10ps

module gcn_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  gcn_types_pkg::coo_t       coo,
    input  gcn_types_pkg::feat_pair_t feat_data,
    input  gcn_types_pkg::wgt_pair_t  wgt_data,
    output logic                      feat_re,
    output gcn_types_pkg::pair_addr_t pair_addr,
    output gcn_types_pkg::class_vec_t y,
    output logic                      done
);
    import gcn_ctrl_pkg::*;
    import gcn_types_pkg::*;

    ctrl_t      ctrl;
    agg_pair_t  agg;
    wgt_stage_t wgt_stage;
    logic       scores_ready;

    // sequencing, drives the shared read address
    gcn_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .scores_ready (scores_ready),
        .ctrl         (ctrl),
        .feat_re      (feat_re),
        .pair_addr    (pair_addr),
        .done         (done)
    );

    // feature side and weight side run in lockstep
    neighbor_aggregator u_agg (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .coo       (coo),
        .feat_data (feat_data),
        .agg       (agg)
    );

    weight_aligner u_wgt (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .wgt_data  (wgt_data),
        .wgt_stage (wgt_stage)
    );

    class_scorer u_score (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .agg          (agg),
        .wgt_stage    (wgt_stage),
        .y            (y),
        .scores_ready (scores_ready)
    );

endmodule

//--- bench/gcn_tb_tasks.svh
// coo entry from two ids
function automatic edge_t make_edge(input int a, input int b);
    edge_t e;
    e.a = node_id_t'(a);
    e.b = node_id_t'(b);
    return e;
endfunction

// ids 0..6, so some entries are empty or self loops
function automatic coo_t random_graph();
    coo_t g;
    for (int e = 0; e < `GCN_EDGES; e++) begin
        g[e] = make_edge(int'($urandom_range(`GCN_NODES, 0)),
                         int'($urandom_range(`GCN_NODES, 0)));
    end
    return g;
endfunction

task automatic randomize_mems();
    for (int f = 0; f < `GCN_FEATS; f++) begin
        for (int n = 0; n < `GCN_NODES; n++) feat_mem[f][n] = feat_t'($urandom_range(31, 0));
        for (int c = 0; c < `GCN_CLASSES; c++) wgt_mem[f][c] = wgt_t'($urandom_range(31, 0));
    end
endtask

task automatic reset_values();
    @(negedge clk);
    compare_bit("reset_values", "done", 1'b0, done);
    compare_bit("reset_values", "feat_re", 1'b0, feat_re);
    compare_classes("reset_values", '0);
    close_test("reset_values");
endtask

task automatic chain_graph();
    coo_t g;
    class_vec_t exp;
    // node m carries feature class m % 3, weight c+1 only on features f % 3 == c
    for (int f = 0; f < `GCN_FEATS; f++) begin
        for (int m = 0; m < `GCN_NODES; m++) begin
            feat_mem[f][m] = ((f % 3) == (m % 3)) ? feat_t'(1) : feat_t'(0);
        end
        for (int c = 0; c < `GCN_CLASSES; c++) begin
            wgt_mem[f][c] = (c == (f % 3)) ? wgt_t'(c + 1) : wgt_t'(0);
        end
    end
    // chain 1-2-3-4-5-6, last entry repeats 5-6 reversed
    for (int e = 0; e < 5; e++) g[e] = make_edge(e + 1, e + 2);
    g[5] = make_edge(6, 5);
    // per class and neighbour 32, 64 or 96
    exp[0] = class_t'(1);
    exp[1] = class_t'(2);
    exp[2] = class_t'(1);
    exp[3] = class_t'(2);
    exp[4] = class_t'(2);
    exp[5] = class_t'(1);
    pulse_start(g);
    wait_done("chain_graph");
    compare_classes("chain_graph", exp);
    close_test("chain_graph");
endtask

task automatic random_graphs();
    coo_t g;
    for (int run = 0; run < 4; run++) begin
        randomize_mems();
        g = random_graph();
        pulse_start(g);
        wait_done("random_graphs");
        compare_classes("random_graphs", ref_classes(g));
    end
    close_test("random_graphs");
endtask

task automatic isolated_nodes();
    coo_t g;
    wgt_t w;
    randomize_mems();
    // only 1-2 is a real edge
    g[0] = make_edge(0, 3);
    g[1] = make_edge(4, 4);
    g[2] = make_edge(1, 2);
    g[3] = make_edge(0, 0);
    g[4] = make_edge(5, 0);
    g[5] = make_edge(6, 6);
    pulse_start(g);
    wait_done("isolated_nodes");
    compare_classes("isolated_nodes", ref_classes(g));
    // isolated nodes score 0 everywhere, class 0 by the tie rule
    for (int n = 2; n < `GCN_NODES; n++) begin
        assert (y[n] == class_t'(0)) else begin
            $display("ERROR isolated_nodes: expected y[%0d]=0, actual y[%0d]=%0d", n, n, y[n]);
            test_errors++;
        end
    end
    // equal class weights tie every node
    for (int f = 0; f < `GCN_FEATS; f++) begin
        w = wgt_t'($urandom_range(31, 0));
        for (int c = 0; c < `GCN_CLASSES; c++) wgt_mem[f][c] = w;
    end
    pulse_start(random_graph());
    wait_done("isolated_nodes");
    compare_classes("isolated_nodes", '0);
    close_test("isolated_nodes");
endtask

task automatic restart_during_run();
    coo_t g_a;
    coo_t g_b;
    class_vec_t exp_a;
    class_vec_t exp_b;
    randomize_mems();
    g_a   = random_graph();
    exp_a = ref_classes(g_a);
    g_b   = random_graph();
    exp_b = ref_classes(g_b);
    // second graph with a different answer where one turns up
    for (int k = 0; k < 20 && exp_b == exp_a; k++) begin
        g_b   = random_graph();
        exp_b = ref_classes(g_b);
    end
    pulse_start(g_a);
    sync_to_fetch("restart_during_run");
    // start in mid fetch carries graph b, must be ignored
    pulse_start(g_b);
    wait_done("restart_during_run");
    compare_classes("restart_during_run", exp_a);
    repeat (5) @(negedge clk);
    compare_classes("restart_during_run", exp_a);
    pulse_start(g_b);
    sync_to_fetch("restart_during_run");
    // previous result still held during the new run
    compare_classes("restart_during_run", exp_a);
    wait_done("restart_during_run");
    compare_classes("restart_during_run", exp_b);
    close_test("restart_during_run");
endtask

//--- bench/gcn_tb.sv
`timescale 1ns/10ps
`include "gcn_settings.svh"

module gcn_tb;
    import gcn_types_pkg::*;

    // a run takes about 60 cycles
    localparam int DONE_TIMEOUT = 200;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start;
    coo_t       coo;
    feat_pair_t feat_data = '0;
    wgt_pair_t  wgt_data = '0;
    logic       feat_re;
    pair_addr_t pair_addr;
    class_vec_t y;
    logic       done;

    // [feature][node] and [feature][class]
    feat_t feat_mem [`GCN_FEATS][`GCN_NODES];
    wgt_t  wgt_mem [`GCN_FEATS][`GCN_CLASSES];

    int test_errors = 0;
    int total_errors = 0;
    int tests_run = 0;
    int tests_failing = 0;

    // reads seen so far in the current fetch phase
    int    read_idx = 0;
    string run_name = "";

    gcn_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .coo       (coo),
        .feat_data (feat_data),
        .wgt_data  (wgt_data),
        .feat_re   (feat_re),
        .pair_addr (pair_addr),
        .y         (y),
        .done      (done)
    );

    always #4 clk = ~clk;

    //////////////////////////////
    // memory models, data one cycle after the pair address
    always @(posedge clk) begin
        if (feat_re) begin
            // pair_addr steps 0..47 through a fetch phase
            assert (int'(pair_addr) == read_idx) else begin
                $display("ERROR %s: expected pair_addr=%0d, actual pair_addr=%0d",
                         run_name, read_idx, pair_addr);
                test_errors++;
            end
            read_idx = read_idx + 1;
            for (int f = 0; f < 2; f++) begin
                for (int n = 0; n < `GCN_NODES; n++) begin
                    feat_data[f][n] <= feat_mem[int'(pair_addr) * 2 + f][n];
                end
                for (int c = 0; c < `GCN_CLASSES; c++) begin
                    wgt_data[f][c] <= wgt_mem[int'(pair_addr) * 2 + f][c];
                end
            end
        end else begin
            read_idx = 0;
        end
    end

    //////////////////////////////
    // reference model
    function automatic class_vec_t ref_classes(input coo_t g);
        logic [`GCN_NODES-1:0] nbr [`GCN_NODES];
        int score [`GCN_CLASSES];
        int a;
        int b;
        int sum;
        int best;
        class_vec_t res;
        for (int n = 0; n < `GCN_NODES; n++) nbr[n] = '0;
        // undirected edges, id 0 and self loops dropped
        for (int e = 0; e < `GCN_EDGES; e++) begin
            a = int'(g[e].a);
            b = int'(g[e].b);
            if (a >= 1 && b >= 1 && a <= `GCN_NODES && b <= `GCN_NODES && a != b) begin
                nbr[a-1][b-1] = 1'b1;
                nbr[b-1][a-1] = 1'b1;
            end
        end
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int c = 0; c < `GCN_CLASSES; c++) score[c] = 0;
            for (int f = 0; f < `GCN_FEATS; f++) begin
                sum = 0;
                for (int m = 0; m < `GCN_NODES; m++) begin
                    if (nbr[n][m]) sum += int'(feat_mem[f][m]);
                end
                for (int c = 0; c < `GCN_CLASSES; c++) score[c] += sum * int'(wgt_mem[f][c]);
            end
            // lowest index wins a tie
            best = 0;
            for (int c = 1; c < `GCN_CLASSES; c++) begin
                if (score[c] > score[best]) best = c;
            end
            res[n] = class_t'(best);
        end
        return res;
    endfunction

    //////////////////////////////
    // sequencing and check helpers
    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, DONE_TIMEOUT);
        test_errors++;
    endtask

    // coo goes out with the start pulse
    task automatic pulse_start(input coo_t g);
        @(posedge clk);
        start <= 1'b1;
        coo   <= g;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(input string name);
        int cycles;
        run_name = name;
        for (cycles = 0; cycles < DONE_TIMEOUT; cycles++) begin
            @(negedge clk);
            if (done) break;
        end
        if (!done) report_timeout({name, ": rise of done"});
    endtask

    task automatic sync_to_fetch(input string name);
        int cycles;
        run_name = name;
        for (cycles = 0; cycles < DONE_TIMEOUT; cycles++) begin
            @(negedge clk);
            if (feat_re) break;
        end
        if (!feat_re) report_timeout({name, ": rise of feat_re"});
    endtask

    task automatic compare_classes(input string name, input class_vec_t exp);
        assert (y == exp) else begin
            $display("ERROR %s: expected y=%h, actual y=%h", name, exp, y);
            test_errors++;
        end
    endtask

    task automatic compare_bit(input string name, input string sig, input logic exp,
                               input logic got);
        assert (got == exp) else begin
            $display("ERROR %s: expected %s=%b, actual %s=%b", name, sig, exp, sig, got);
            test_errors++;
        end
    endtask

    task automatic close_test(input string name);
        if (test_errors == 0) begin
            $display("%-20s ok", name);
        end else begin
            $display("%-20s FAILED with %0d errors", name, test_errors);
            tests_failing++;
        end
        total_errors += test_errors;
        tests_run++;
        test_errors = 0;
    endtask

    `include "gcn_tb_tasks.svh"

    initial begin
        void'($urandom(56));
        rst_n = 1'b0;
        start = 1'b0;
        coo   = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        chain_graph();
        random_graphs();
        isolated_nodes();
        restart_during_run();
        $display("tests run: %0d, failing: %0d, errors: %0d",
                 tests_run, tests_failing, total_errors);
        if (tests_failing == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
+incdir+bench
rtl/gcn_types_pkg.sv
rtl/gcn_ctrl_pkg.sv
rtl/gcn_ctrl.sv
rtl/neighbor_aggregator.sv
rtl/weight_aligner.sv
rtl/class_scorer.sv
rtl/gcn_top.sv
bench/gcn_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the gcn testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module gcn_tb -o gcn_sim \
    || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/gcn_sim)"
echo "${sim_out}"

# pass only if the testbench printed its pass line
grep -qx "test passed" <<< "${sim_out}" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
